// ==== verilog.f ====
+incdir+source
source/router_pkg.sv
source/router_input_fifo.sv
source/xy_route_select.sv
source/output_arbiter.sv
source/mesh_router.sv
dv/tb_mesh_router.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_mesh_router -f verilog.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "sim passed" || exit 1

// ==== dv/tb_mesh_router.sv ====
// ==========================================================
// Testbench for the five-port XY mesh router
// Legal traffic checked by a scoreboard per (output, source) pair
// ==========================================================
`timescale 1ns/1ps
`include "router_defines.svh"

module tb_mesh_router;
  import router_pkg::*;

  localparam int N     = `ROUTER_NUM_PORTS;
  localparam int CW    = `ROUTER_COORD_WIDTH;
  localparam int DEPTH = `ROUTER_FIFO_DEPTH;
  // Router sits at tile (3,3)
  localparam int MY_X  = 3;
  localparam int MY_Y  = 3;

  // Starts low without an edge at time zero
  logic              clk_i = 1'b0;
  logic              rst_i;
  xy_coord_t         xy_id_i;
  logic     [N-1:0]  valid_i;
  logic     [N-1:0]  ready_o;
  flit_t    [N-1:0]  data_i;
  logic     [N-1:0]  valid_o;
  logic     [N-1:0]  ready_i;
  flit_t    [N-1:0]  data_o;

  // Flits waiting to be offered on each input
  flit_t        send_q [N][$];
  // Expected flits indexed by out*N + src
  flit_t        sb_q [N*N][$];
  logic [N-1:0] fire_in;
  logic [N-1:0] stall_q;
  flit_t        stall_data [N];
  // Bit w of entry j set when input w won Eject since input j last won
  logic [N-1:0] granted_since [N];
  // Mode 0 keeps outputs ready while 1 draws ready at random and 2 blocks them
  logic [1:0]   ready_mode;
  logic         check_fair;
  logic [31:0]  rng_state;
  string        test_name;
  int           error_count;
  int           check_count;
  int           flits_sent;
  int           cycle_count;
  int           in_count [N];

  mesh_router mesh_router_i (
    .clk_i   ( clk_i   ),
    .rst_i   ( rst_i   ),
    .xy_id_i ( xy_id_i ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .data_i  ( data_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .data_o  ( data_o  )
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // Expected output port with X resolved before Y
  function automatic port_e ref_route(input xy_coord_t dst);
    if (int'(dst.x) > MY_X) return port_east;
    if (int'(dst.x) < MY_X) return port_west;
    if (int'(dst.y) > MY_Y) return port_north;
    if (int'(dst.y) < MY_Y) return port_south;
    return port_eject;
  endfunction

  // No loopback and Y inputs stay in their column
  function automatic logic is_legal(input port_e src, input xy_coord_t dst);
    port_e exp_port;
    exp_port = ref_route(dst);
    if (exp_port == src) return 1'b0;
    if ((src == port_north || src == port_south) && int'(dst.x) != MY_X) return 1'b0;
    return 1'b1;
  endfunction

  task automatic queue_flit(input port_e src, input xy_coord_t dst);
    flit_t f;
    f.hdr.dst = dst;
    f.hdr.src = src;
    f.payload = next_rand();
    send_q[int'(src)].push_back(f);
    flits_sent++;
  endtask

  task automatic queue_random(input port_e src, input int count);
    xy_coord_t   dst;
    logic [31:0] r;
    int          sent;
    sent = 0;
    // Redraw until the destination is legal for this input
    while (sent < count) begin
      r = next_rand();
      dst.x = r[CW-1:0];
      dst.y = r[2*CW-1:CW];
      if (is_legal(src, dst)) begin
        queue_flit(src, dst);
        sent++;
      end
    end
  endtask

  task automatic wait_drain();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      busy = 1'b0;
      for (int p = 0; p < N; p++) begin
        if (send_q[p].size() != 0) busy = 1'b1;
      end
      for (int q = 0; q < N*N; q++) begin
        if (sb_q[q].size() != 0) busy = 1'b1;
      end
    end
  endtask

  task automatic check_idle();
    if (valid_o !== '0) begin
      error_count++;
      $display("[ERROR] %s: valid_o expected %b actual %b", test_name, {N{1'b0}}, valid_o);
    end
    if (ready_o !== '1) begin
      error_count++;
      $display("[ERROR] %s: ready_o expected %b actual %b", test_name, {N{1'b1}}, ready_o);
    end
  endtask

  // A waiting input must be served before the winner wins again
  task automatic check_fairness(input int w);
    for (int j = 0; j < N; j++) begin
      if (j != w && sb_q[int'(port_eject)*N + j].size() != 0) begin
        if (granted_since[j][w]) begin
          error_count++;
          $display("Input %0d won Eject twice while input %0d waited in %s", w, j, test_name);
        end
        granted_since[j][w] = 1'b1;
      end
    end
    granted_since[w] = '0;
  endtask

  task automatic check_output(input int o);
    flit_t got;
    flit_t exp;
    int    src;
    got = data_o[o];
    // Stalled flit must hold until taken
    if (stall_q[o]) begin
      if (!valid_o[o]) begin
        error_count++;
        $display("Output %0d dropped valid_o before ready_i in %s", o, test_name);
      end else if (got !== stall_data[o]) begin
        error_count++;
        $display("[ERROR] %s: stalled data_o[%0d] expected %h actual %h",
                 test_name, o, stall_data[o], got);
      end
    end
    stall_q[o]    = valid_o[o] & ~ready_i[o];
    stall_data[o] = got;
    if (valid_o[o] && ready_i[o]) begin
      src = int'(got.hdr.src);
      if (src >= N) begin
        error_count++;
        $display("Output %0d carried a flit with a bad source port in %s", o, test_name);
      end else if (sb_q[o*N + src].size() == 0) begin
        error_count++;
        $display("Output %0d sent a flit from input %0d that was not expected in %s",
                 o, src, test_name);
      end else begin
        exp = sb_q[o*N + src].pop_front();
        check_count++;
        if (got !== exp) begin
          error_count++;
          $display("[ERROR] %s: data_o[%0d] expected %h actual %h", test_name, o, exp, got);
        end
        if (check_fair && o == int'(port_eject)) check_fairness(src);
      end
    end
  endtask

  task automatic record_input(input int p);
    port_e exp_port;
    fire_in[p] = valid_i[p] & ready_o[p];
    if (fire_in[p]) begin
      exp_port = ref_route(data_i[p].hdr.dst);
      sb_q[int'(exp_port)*N + p].push_back(data_i[p]);
      in_count[p]++;
    end
  endtask

  // Monitor at the falling edge checks outputs before this cycle's inputs
  always @(negedge clk_i) begin
    if (rst_i) begin
      fire_in = '0;
      stall_q = '0;
      check_idle();
    end else begin
      for (int o = 0; o < N; o++) check_output(o);
      for (int p = 0; p < N; p++) record_input(p);
    end
  end

  // Driver acts 1 ns after the rising edge
  always @(posedge clk_i) begin
    logic [31:0] r;
    #1;
    for (int p = 0; p < N; p++) begin
      if (fire_in[p]) void'(send_q[p].pop_front());
      if (rst_i || send_q[p].size() == 0) begin
        valid_i[p] = 1'b0;
      end else begin
        valid_i[p] = 1'b1;
        data_i[p]  = send_q[p][0];
      end
    end
    r = next_rand();
    for (int p = 0; p < N; p++) begin
      case (ready_mode)
        2'd1:    ready_i[p] = (r[2*p +: 2] != 2'b00);
        2'd2:    ready_i[p] = 1'b0;
        default: ready_i[p] = 1'b1;
      endcase
    end
  end

  // Bound grows with the traffic queued so far
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > flits_sent * 8 + 200) begin
      $display("Timeout after %0d cycles with flits still in the router", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    xy_coord_t dst;
    int        base;
    rst_i       = 1'b1;
    xy_id_i.x   = CW'(MY_X);
    xy_id_i.y   = CW'(MY_Y);
    valid_i     = '0;
    ready_i     = '1;
    data_i      = '0;
    fire_in     = '0;
    stall_q     = '0;
    ready_mode  = 2'd0;
    check_fair  = 1'b0;
    rng_state   = 32'h55c5_d735;
    test_name   = "reset";
    error_count = 0;
    check_count = 0;
    flits_sent  = 0;
    cycle_count = 0;
    for (int p = 0; p < N; p++) begin
      in_count[p]      = 0;
      granted_since[p] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_idle();

    // Every legal destination from every input
    test_name = "routing";
    for (int p = 0; p < N; p++) begin
      for (int x = 0; x < (1 << CW); x++) begin
        for (int y = 0; y < (1 << CW); y++) begin
          dst.x = CW'(x);
          dst.y = CW'(y);
          if (is_legal(port_e'(p), dst)) queue_flit(port_e'(p), dst);
        end
      end
    end
    wait_drain();

    test_name  = "backpressure";
    ready_mode = 2'd1;
    for (int p = 0; p < N; p++) queue_random(port_e'(p), 40);
    wait_drain();

    // With every output blocked the West input fills its FIFO and stops
    test_name  = "fifo full";
    ready_mode = 2'd2;
    @(negedge clk_i);
    base  = in_count[int'(port_west)];
    dst.x = CW'(MY_X);
    dst.y = CW'(MY_Y);
    repeat (6) queue_flit(port_west, dst);
    repeat (12) @(negedge clk_i);
    if (in_count[int'(port_west)] - base != DEPTH) begin
      error_count++;
      $display("[ERROR] %s: flits accepted expected %0d actual %0d",
               test_name, DEPTH, in_count[int'(port_west)] - base);
    end
    if (ready_o[int'(port_west)] !== 1'b0) begin
      error_count++;
      $display("[ERROR] %s: ready_o[west] expected 0 actual %b",
               test_name, ready_o[int'(port_west)]);
    end
    ready_mode = 2'd0;
    wait_drain();

    // East, South and West all aimed at Eject
    test_name  = "fairness";
    check_fair = 1'b1;
    for (int p = 0; p < N; p++) granted_since[p] = '0;
    repeat (8) begin
      queue_flit(port_east, dst);
      queue_flit(port_south, dst);
      queue_flit(port_west, dst);
    end
    wait_drain();
    check_fair = 1'b0;

    $display("Done: %0d flits sent, %0d compared, %0d errors",
             flits_sent, check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== source/mesh_router.sv ====
// ==========================================================
// Five-port mesh router with XY routing
// Input FIFOs, route select, crossbar and output arbiters
// ==========================================================
`timescale 1ns/1ps
`include "router_defines.svh"

module mesh_router (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  router_pkg::xy_coord_t                     xy_id_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]              valid_i,
  output logic [`ROUTER_NUM_PORTS-1:0]              ready_o,
  input  router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0] data_i,
  output logic [`ROUTER_NUM_PORTS-1:0]              valid_o,
  input  logic [`ROUTER_NUM_PORTS-1:0]              ready_i,
  output router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0] data_o
);
  import router_pkg::*;

  localparam int unsigned N = `ROUTER_NUM_PORTS;

  // FIFO heads, indexed by input
  flit_t       [N-1:0] head_data;
  logic        [N-1:0] head_valid;
  logic        [N-1:0] head_pop;
  route_mask_t [N-1:0] route_mask;

  // Crossbar signals, [out][in] for arbiters and [in][out] for pops
  route_mask_t [N-1:0]         xbar_req;
  flit_t       [N-1:0][N-1:0]  xbar_data;
  route_mask_t [N-1:0]         out_gnt;
  route_mask_t [N-1:0]         in_gnt;

  for (genvar in = 0; in < N; in++) begin : gen_input
    router_input_fifo i_input_fifo (
      .clk_i   ( clk_i          ),
      .rst_i   ( rst_i          ),
      .valid_i ( valid_i[in]    ),
      .ready_o ( ready_o[in]    ),
      .data_i  ( data_i[in]     ),
      .valid_o ( head_valid[in] ),
      .pop_i   ( head_pop[in]   ),
      .data_o  ( head_data[in]  )
    );

    xy_route_select i_route_select (
      .xy_id_i ( xy_id_i               ),
      .dst_i   ( head_data[in].hdr.dst ),
      .route_o ( route_mask[in]        )
    );

    // Unicast, so any one output grant retires the head
    assign head_pop[in] = |in_gnt[in];
  end

  for (genvar in = 0; in < N; in++) begin : gen_xbar_in
    for (genvar out = 0; out < N; out++) begin : gen_xbar_out
      // Loopback and Y-to-X turns never occur under XY routing
      if ((in == out) ||
          (((in == int'(port_north)) || (in == int'(port_south))) &&
           ((out == int'(port_east)) || (out == int'(port_west))))) begin : gen_no_conn
        assign xbar_req[out][in]  = 1'b0;
        assign xbar_data[out][in] = '0;
        assign in_gnt[in][out]    = 1'b0;
      end else begin : gen_conn
        assign xbar_req[out][in]  = head_valid[in] & route_mask[in][out];
        assign xbar_data[out][in] = head_data[in];
        assign in_gnt[in][out]    = out_gnt[out][in];
      end
    end
  end

  for (genvar out = 0; out < N; out++) begin : gen_output
    output_arbiter i_output_arbiter (
      .clk_i   ( clk_i          ),
      .rst_i   ( rst_i          ),
      .req_i   ( xbar_req[out]  ),
      .data_i  ( xbar_data[out] ),
      .gnt_o   ( out_gnt[out]   ),
      .valid_o ( valid_o[out]   ),
      .ready_i ( ready_i[out]   ),
      .data_o  ( data_o[out]    )
    );
  end

endmodule

// ==== source/output_arbiter.sv ====
// ==========================================================
// Output arbiter
// Round-robin choice among inputs for one output port
// ==========================================================
`timescale 1ns/1ps
`include "router_defines.svh"

module output_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  router_pkg::route_mask_t                      req_i,
  input  router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]    data_i,
  output router_pkg::route_mask_t                      gnt_o,
  output logic                                         valid_o,
  input  logic                                         ready_i,
  output router_pkg::flit_t                            data_o
);

  localparam int unsigned N     = `ROUTER_NUM_PORTS;
  localparam int unsigned IDX_W = $clog2(N);

  // Highest priority input for the next decision
  logic [IDX_W-1:0] ptr_q;
  // Winner locked while the output is stalled
  logic             hold_q;
  logic [IDX_W-1:0] hold_idx_q;
  logic [IDX_W-1:0] rr_idx;
  logic [IDX_W-1:0] win_idx;

  // First requester at or after the pointer, wrapping around
  always_comb begin : rr_search
    int unsigned cand;
    logic        found;
    found  = 1'b0;
    rr_idx = ptr_q;
    for (int unsigned k = 0; k < N; k++) begin
      cand = ptr_q + k;
      if (cand >= N) begin
        cand = cand - N;
      end
      if (!found && req_i[cand]) begin
        found  = 1'b1;
        rr_idx = IDX_W'(cand);
      end
    end
  end

  // A stalled winner keeps the output, so data_o stays put
  assign win_idx = hold_q ? hold_idx_q : rr_idx;
  assign valid_o = |req_i;
  assign data_o  = data_i[win_idx];

  // Grant only on a completed handshake, doubles as the FIFO pop
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = valid_o & ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= valid_o & ~ready_i;
      hold_idx_q <= win_idx;
      // Move past the winner after it is served
      if (valid_o && ready_i) begin
        ptr_q <= (win_idx == IDX_W'(N - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

endmodule

// ==== source/xy_route_select.sv ====
// ==========================================================
// XY route select
// Picks the one-hot output port, X dimension first
// ==========================================================
`timescale 1ns/1ps

module xy_route_select (
  input  router_pkg::xy_coord_t   xy_id_i,
  input  router_pkg::xy_coord_t   dst_i,
  output router_pkg::route_mask_t route_o
);
  import router_pkg::*;

  // Selected output as a port index
  port_e out_port;

  always_comb begin
    // X first, so a flit only turns into Y once its column matches
    if (dst_i.x > xy_id_i.x) begin
      out_port = port_east;
    end else if (dst_i.x < xy_id_i.x) begin
      out_port = port_west;
    // Same column, now resolve the row
    end else if (dst_i.y > xy_id_i.y) begin
      out_port = port_north;
    end else if (dst_i.y < xy_id_i.y) begin
      out_port = port_south;
    end else begin
      // Arrived at this tile
      out_port = port_eject;
    end
  end

  // Decode to one-hot, exactly one bit set
  always_comb begin
    route_o           = '0;
    route_o[out_port] = 1'b1;
  end

endmodule

// ==== source/router_input_fifo.sv ====
// ==========================================================
// Input FIFO for one router port
// Circular buffer with a registered head
// ==========================================================
`timescale 1ns/1ps
`include "router_defines.svh"

module router_input_fifo (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  router_pkg::flit_t data_i,
  output logic              valid_o,
  input  logic              pop_i,
  output router_pkg::flit_t data_o
);
  import router_pkg::*;

  localparam int unsigned DEPTH = `ROUTER_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  // Flit storage
  flit_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // When full, a same-cycle pop frees the slot for the new flit
  assign ready_o = ~full | pop_i;
  assign pop     = pop_i & valid_o;
  assign push    = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at the last entry
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill level, unchanged on push with pop
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== source/router_pkg.sv ====
// ==========================================================
// Mesh router types
// Port indices, coordinates and the single-flit packet
// ==========================================================
`include "router_defines.svh"

package router_pkg;

  // Port index, also the bit position in a route mask
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_east  = 3'd1,
    port_south = 3'd2,
    port_west  = 3'd3,
    port_eject = 3'd4
  } port_e;

  // Tile position in the mesh
  typedef struct packed {
    logic [`ROUTER_COORD_WIDTH-1:0] x;
    logic [`ROUTER_COORD_WIDTH-1:0] y;
  } xy_coord_t;

  // Destination tile plus the port the flit entered on
  typedef struct packed {
    xy_coord_t dst;
    port_e     src;
  } flit_hdr_t;

  // A whole packet fits in one flit
  typedef struct packed {
    flit_hdr_t                        hdr;
    logic [`ROUTER_PAYLOAD_WIDTH-1:0] payload;
  } flit_t;

  // One bit per port, one-hot when used as a route
  typedef logic [`ROUTER_NUM_PORTS-1:0] route_mask_t;

endpackage

// ==== source/router_defines.svh ====
// ==========================================================
// Mesh router sizing constants
// ==========================================================
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// North, East, South, West and the local Eject port
`define ROUTER_NUM_PORTS 5

// Bits per X or Y mesh coordinate
`define ROUTER_COORD_WIDTH 3

// Payload bits carried by every flit
`define ROUTER_PAYLOAD_WIDTH 32

// Entries in each input FIFO
`define ROUTER_FIFO_DEPTH 4

`endif
